// File: design/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // sram depth in words, word index taken from address bits 9:2
    localparam int MEM_WORDS    = 256;
    localparam int WORD_IDX_W   = $clog2(MEM_WORDS);
    localparam int WORD_IDX_LSB = 2;

    // cycles from accepted read address to rvalid
    localparam int SRAM_LAT  = 2;
    localparam int LAT_CNT_W = $clog2(SRAM_LAT + 1);

    typedef logic [ADDR_W-1:0]     bus_addr_t;
    typedef logic [DATA_W-1:0]     bus_data_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [LAT_CNT_W-1:0]  lat_cnt_t;

    // bus owner as seen by the arbiter
    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_FETCH_RD,
        GRANT_LSU_RD,
        GRANT_LSU_WR
    } grant_e;

endpackage

// File: design/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // fetch master, read only
    input  bus_addr_t fetch_araddr,
    input  logic      fetch_arvalid,
    output logic      fetch_arready,
    input  logic      fetch_rready,
    output logic      fetch_rvalid,
    output bus_data_t fetch_rdata,

    // load/store master
    input  bus_addr_t lsu_araddr,
    input  logic      lsu_arvalid,
    output logic      lsu_arready,
    input  logic      lsu_rready,
    output logic      lsu_rvalid,
    output bus_data_t lsu_rdata,
    input  bus_addr_t lsu_awaddr,
    input  logic      lsu_awvalid,
    output logic      lsu_awready,
    input  bus_data_t lsu_wdata,
    input  logic      lsu_wvalid,
    output logic      lsu_wready,
    input  logic      lsu_bready,
    output logic      lsu_bvalid,

    // toward the slave
    output bus_addr_t saxi_araddr,
    output logic      saxi_arvalid,
    input  logic      saxi_arready,
    output logic      saxi_rready,
    input  logic      saxi_rvalid,
    input  bus_data_t saxi_rdata,
    output bus_addr_t saxi_awaddr,
    output logic      saxi_awvalid,
    input  logic      saxi_awready,
    output bus_data_t saxi_wdata,
    output logic      saxi_wvalid,
    input  logic      saxi_wready,
    output logic      saxi_bready,
    input  logic      saxi_bvalid
);

    grant_e state;

    // fixed priority when free: fetch read, lsu read, lsu write
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GRANT_IDLE;
        end else begin
            case (state)
                GRANT_IDLE: begin
                    if (fetch_arvalid)
                        state <= GRANT_FETCH_RD;
                    else if (lsu_arvalid)
                        state <= GRANT_LSU_RD;
                    else if (lsu_awvalid || lsu_wvalid)
                        state <= GRANT_LSU_WR;
                end
                // release on the owner's last response beat
                GRANT_FETCH_RD: if (saxi_rvalid && fetch_rready) state <= GRANT_IDLE;
                GRANT_LSU_RD:   if (saxi_rvalid && lsu_rready) state <= GRANT_IDLE;
                GRANT_LSU_WR:   if (saxi_bvalid && lsu_bready) state <= GRANT_IDLE;
                default:        state <= GRANT_IDLE;
            endcase
        end
    end

    // channel muxing, purely from the grant
    always_comb begin
        // nobody owns anything by default
        saxi_araddr   = '0;
        saxi_arvalid  = 1'b0;
        saxi_rready   = 1'b0;
        saxi_awaddr   = '0;
        saxi_awvalid  = 1'b0;
        saxi_wdata    = '0;
        saxi_wvalid   = 1'b0;
        saxi_bready   = 1'b0;
        fetch_arready = 1'b0;
        fetch_rvalid  = 1'b0;
        fetch_rdata   = '0;
        lsu_arready   = 1'b0;
        lsu_rvalid    = 1'b0;
        lsu_rdata     = '0;
        lsu_awready   = 1'b0;
        lsu_wready    = 1'b0;
        lsu_bvalid    = 1'b0;

        case (state)
            GRANT_FETCH_RD: begin
                saxi_araddr   = fetch_araddr;
                saxi_arvalid  = fetch_arvalid;
                saxi_rready   = fetch_rready;
                fetch_arready = saxi_arready;
                fetch_rvalid  = saxi_rvalid;
                fetch_rdata   = saxi_rdata;
            end
            GRANT_LSU_RD: begin
                saxi_araddr  = lsu_araddr;
                saxi_arvalid = lsu_arvalid;
                saxi_rready  = lsu_rready;
                lsu_arready  = saxi_arready;
                lsu_rvalid   = saxi_rvalid;
                lsu_rdata    = saxi_rdata;
            end
            GRANT_LSU_WR: begin
                // aw and w go through together, slave takes each on its own
                saxi_awaddr  = lsu_awaddr;
                saxi_awvalid = lsu_awvalid;
                saxi_wdata   = lsu_wdata;
                saxi_wvalid  = lsu_wvalid;
                saxi_bready  = lsu_bready;
                lsu_awready  = saxi_awready;
                lsu_wready   = saxi_wready;
                lsu_bvalid   = saxi_bvalid;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/fetch_bus_master.sv
`timescale 1ns/10ps

module fetch_bus_master
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // fetch request side
    input  logic      fetch_req,
    input  bus_addr_t fetch_addr,
    output logic      fetch_done,
    output bus_data_t fetch_data,
    output logic      fetch_busy,

    // read channels toward the arbiter
    output bus_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    output logic      rready,
    input  logic      rvalid,
    input  bus_data_t rdata
);

    typedef enum logic [1:0] {F_IDLE, F_ADDR, F_WAIT} fetch_state_e;

    fetch_state_e state;
    bus_addr_t    addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= F_IDLE;
            fetch_done <= 1'b0;
        end else begin
            // done is a single cycle pulse
            fetch_done <= 1'b0;
            case (state)
                F_IDLE:  if (fetch_req) state <= F_ADDR;
                F_ADDR:  if (arready) state <= F_WAIT;
                F_WAIT: begin
                    if (rvalid) begin
                        state      <= F_IDLE;
                        fetch_done <= 1'b1;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // operand and instruction word latches
    always_ff @(posedge clk) begin
        if (state == F_IDLE && fetch_req)
            addr_q <= fetch_addr;
        if (state == F_WAIT && rvalid)
            fetch_data <= rdata;
    end

    assign araddr     = addr_q;
    assign arvalid    = (state == F_ADDR);
    // ready for the data beat only once the address went out
    assign rready     = (state == F_WAIT);
    assign fetch_busy = (state != F_IDLE);

endmodule

// File: design/lsu_bus_master.sv
`timescale 1ns/10ps

module lsu_bus_master
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // load/store request side
    input  logic      lsu_req,
    input  logic      lsu_we,
    input  bus_addr_t lsu_addr,
    input  bus_data_t lsu_wdata,
    output logic      lsu_done,
    output bus_data_t lsu_rdata,
    output logic      lsu_busy,

    // bus channels toward the arbiter
    output bus_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    output logic      rready,
    input  logic      rvalid,
    input  bus_data_t rdata,
    output bus_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    output bus_data_t wdata,
    output logic      wvalid,
    input  logic      wready,
    output logic      bready,
    input  logic      bvalid
);

    typedef enum logic [2:0] {L_IDLE, L_RD_ADDR, L_RD_DATA, L_WR_REQ, L_WR_RESP} lsu_state_e;

    lsu_state_e state;
    bus_addr_t  addr_q;
    bus_data_t  wdata_q;
    logic       aw_pend;
    logic       w_pend;
    logic       aw_left;
    logic       w_left;

    // beats still outstanding after this edge
    assign aw_left = aw_pend && !awready;
    assign w_left  = w_pend && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= L_IDLE;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                L_IDLE: begin
                    if (lsu_req && lsu_we) begin
                        state   <= L_WR_REQ;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end else if (lsu_req) begin
                        state <= L_RD_ADDR;
                    end
                end
                L_RD_ADDR: if (arready) state <= L_RD_DATA;
                L_RD_DATA: begin
                    if (rvalid) begin
                        state    <= L_IDLE;
                        lsu_done <= 1'b1;
                    end
                end
                L_WR_REQ: begin
                    // each valid drops on its own beat
                    aw_pend <= aw_left;
                    w_pend  <= w_left;
                    if (!aw_left && !w_left)
                        state <= L_WR_RESP;
                end
                L_WR_RESP: begin
                    if (bvalid) begin
                        state    <= L_IDLE;
                        lsu_done <= 1'b1;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // operands and load result
    always_ff @(posedge clk) begin
        if (state == L_IDLE && lsu_req) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
        end
        if (state == L_RD_DATA && rvalid)
            lsu_rdata <= rdata;
    end

    assign araddr   = addr_q;
    assign arvalid  = (state == L_RD_ADDR);
    assign rready   = (state == L_RD_DATA);
    assign awaddr   = addr_q;
    assign awvalid  = (state == L_WR_REQ) && aw_pend;
    assign wdata    = wdata_q;
    assign wvalid   = (state == L_WR_REQ) && w_pend;
    assign bready   = (state == L_WR_RESP);
    assign lsu_busy = (state != L_IDLE);

endmodule

// File: design/sram_slave.sv
`timescale 1ns/10ps

module sram_slave
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // read address / data
    input  bus_addr_t s_araddr,
    input  logic      s_arvalid,
    output logic      s_arready,
    input  logic      s_rready,
    output logic      s_rvalid,
    output bus_data_t s_rdata,

    // write address / data / response
    input  bus_addr_t s_awaddr,
    input  logic      s_awvalid,
    output logic      s_awready,
    input  bus_data_t s_wdata,
    input  logic      s_wvalid,
    output logic      s_wready,
    input  logic      s_bready,
    output logic      s_bvalid
);

    bus_data_t mem [MEM_WORDS];

    lat_cnt_t  rd_cnt;
    word_idx_t rd_idx;
    word_idx_t wr_idx;
    bus_data_t wr_data;
    logic      aw_taken;
    logic      w_taken;
    logic      ar_fire;
    logic      wr_fire;

    assign ar_fire = s_arvalid && s_arready;
    // both write beats in hand
    assign wr_fire = aw_taken && w_taken;

    // idle read side: no countdown and no data waiting
    assign s_arready = (rd_cnt == '0) && !s_rvalid;
    // each write beat taken once per transaction
    assign s_awready = !aw_taken && !s_bvalid;
    assign s_wready  = !w_taken && !s_bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt   <= '0;
            s_rvalid <= 1'b0;
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            // read latency countdown
            if (ar_fire)
                rd_cnt <= lat_cnt_t'(SRAM_LAT);
            else if (rd_cnt != '0)
                rd_cnt <= rd_cnt - lat_cnt_t'(1);

            if (rd_cnt == lat_cnt_t'(1))
                s_rvalid <= 1'b1;
            else if (s_rvalid && s_rready)
                s_rvalid <= 1'b0;

            // write beat flags
            if (wr_fire) begin
                aw_taken <= 1'b0;
                w_taken  <= 1'b0;
            end else begin
                if (s_awvalid && s_awready)
                    aw_taken <= 1'b1;
                if (s_wvalid && s_wready)
                    w_taken <= 1'b1;
            end

            if (wr_fire)
                s_bvalid <= 1'b1;
            else if (s_bvalid && s_bready)
                s_bvalid <= 1'b0;
        end
    end

    // array and beat payloads
    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_idx <= s_araddr[WORD_IDX_LSB +: WORD_IDX_W];
        if (rd_cnt == lat_cnt_t'(1))
            s_rdata <= mem[rd_idx];
        if (s_awvalid && s_awready)
            wr_idx <= s_awaddr[WORD_IDX_LSB +: WORD_IDX_W];
        if (s_wvalid && s_wready)
            wr_data <= s_wdata;
        if (wr_fire)
            mem[wr_idx] <= wr_data;
    end

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top (
    input  logic                   clk,
    input  logic                   rst,

    // fetch port
    input  logic                   fetch_req,
    input  mem_bus_pkg::bus_addr_t fetch_addr,
    output logic                   fetch_done,
    output mem_bus_pkg::bus_data_t fetch_data,
    output logic                   fetch_busy,

    // load/store port
    input  logic                   lsu_req,
    input  logic                   lsu_we,
    input  mem_bus_pkg::bus_addr_t lsu_addr,
    input  mem_bus_pkg::bus_data_t lsu_wdata,
    output logic                   lsu_done,
    output mem_bus_pkg::bus_data_t lsu_rdata,
    output logic                   lsu_busy
);

    // fetch master to arbiter
    mem_bus_pkg::bus_addr_t f_araddr;
    logic                   f_arvalid, f_arready, f_rready, f_rvalid;
    mem_bus_pkg::bus_data_t f_rdata;

    // lsu master to arbiter
    mem_bus_pkg::bus_addr_t l_araddr, l_awaddr;
    mem_bus_pkg::bus_data_t l_rdata, l_wdata;
    logic                   l_arvalid, l_arready, l_rready, l_rvalid;
    logic                   l_awvalid, l_awready, l_wvalid, l_wready;
    logic                   l_bready, l_bvalid;

    // arbiter to sram
    mem_bus_pkg::bus_addr_t s_araddr, s_awaddr;
    mem_bus_pkg::bus_data_t s_rdata, s_wdata;
    logic                   s_arvalid, s_arready, s_rready, s_rvalid;
    logic                   s_awvalid, s_awready, s_wvalid, s_wready;
    logic                   s_bready, s_bvalid;

    fetch_bus_master u_fetch (
        .clk, .rst,
        .fetch_req, .fetch_addr, .fetch_done, .fetch_data, .fetch_busy,
        .araddr (f_araddr), .arvalid(f_arvalid), .arready(f_arready),
        .rready (f_rready), .rvalid (f_rvalid),  .rdata  (f_rdata)
    );

    lsu_bus_master u_lsu (
        .clk, .rst,
        .lsu_req, .lsu_we, .lsu_addr, .lsu_wdata, .lsu_done, .lsu_rdata, .lsu_busy,
        .araddr (l_araddr), .arvalid(l_arvalid), .arready(l_arready),
        .rready (l_rready), .rvalid (l_rvalid),  .rdata  (l_rdata),
        .awaddr (l_awaddr), .awvalid(l_awvalid), .awready(l_awready),
        .wdata  (l_wdata),  .wvalid (l_wvalid),  .wready (l_wready),
        .bready (l_bready), .bvalid (l_bvalid)
    );

    bus_arbiter u_arb (
        .clk, .rst,
        .fetch_araddr (f_araddr), .fetch_arvalid(f_arvalid), .fetch_arready(f_arready),
        .fetch_rready (f_rready), .fetch_rvalid (f_rvalid),  .fetch_rdata  (f_rdata),
        .lsu_araddr   (l_araddr), .lsu_arvalid  (l_arvalid), .lsu_arready  (l_arready),
        .lsu_rready   (l_rready), .lsu_rvalid   (l_rvalid),  .lsu_rdata    (l_rdata),
        .lsu_awaddr   (l_awaddr), .lsu_awvalid  (l_awvalid), .lsu_awready  (l_awready),
        .lsu_wdata    (l_wdata),  .lsu_wvalid   (l_wvalid),  .lsu_wready   (l_wready),
        .lsu_bready   (l_bready), .lsu_bvalid   (l_bvalid),
        .saxi_araddr  (s_araddr), .saxi_arvalid (s_arvalid), .saxi_arready (s_arready),
        .saxi_rready  (s_rready), .saxi_rvalid  (s_rvalid),  .saxi_rdata   (s_rdata),
        .saxi_awaddr  (s_awaddr), .saxi_awvalid (s_awvalid), .saxi_awready (s_awready),
        .saxi_wdata   (s_wdata),  .saxi_wvalid  (s_wvalid),  .saxi_wready  (s_wready),
        .saxi_bready  (s_bready), .saxi_bvalid  (s_bvalid)
    );

    sram_slave u_sram (
        .clk, .rst,
        .s_araddr, .s_arvalid, .s_arready, .s_rready, .s_rvalid, .s_rdata,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wvalid, .s_wready,
        .s_bready, .s_bvalid
    );

endmodule

// File: test/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem
    import mem_bus_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 50;
    localparam logic [31:0] SEED           = 32'h1a09_2e95;

    logic      clk;
    logic      rst;
    logic      fetch_req;
    bus_addr_t fetch_addr;
    logic      fetch_done;
    bus_data_t fetch_data;
    logic      fetch_busy;
    logic      lsu_req;
    logic      lsu_we;
    bus_addr_t lsu_addr;
    bus_data_t lsu_wdata;
    logic      lsu_done;
    bus_data_t lsu_rdata;
    logic      lsu_busy;

    // reference memory, word index is address bits 9:2
    bus_data_t   ref_mem   [MEM_WORDS];
    logic        ref_valid [MEM_WORDS];
    logic [31:0] rng;

    mem_subsystem_top uut (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_data (fetch_data),
        .fetch_busy (fetch_busy),
        .lsu_req    (lsu_req),
        .lsu_we     (lsu_we),
        .lsu_addr   (lsu_addr),
        .lsu_wdata  (lsu_wdata),
        .lsu_done   (lsu_done),
        .lsu_rdata  (lsu_rdata),
        .lsu_busy   (lsu_busy)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // quiet cycles, nothing may finish and nobody is busy
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_value("fetch_done", 32'd0, fetch_done);
            check_value("fetch_busy", 32'd0, fetch_busy);
            check_value("lsu_done", 32'd0, lsu_done);
            check_value("lsu_busy", 32'd0, lsu_busy);
        end
    endtask

    // one port's done/busy/data seen at the falling edge
    task automatic watch_side(
        input string     side,
        input string     data_name,
        input logic      active,
        input logic      check_data,
        input logic      done_now,
        input logic      busy_now,
        input bus_data_t data_now,
        input bus_data_t expected,
        input int        cyc,
        inout logic      seen,
        inout int        seen_cyc
    );
        if (done_now) begin
            if (!active || seen) begin
                $display("%s_done pulsed at %0t ns with no request outstanding", side, $time);
                stop_with_failure();
            end
            seen     = 1'b1;
            seen_cyc = cyc;
            // busy drops together with done
            check_value({side, "_busy"}, 32'd0, busy_now);
            if (check_data)
                check_value(data_name, expected, data_now);
        end else if (active && !seen) begin
            check_value({side, "_busy"}, 32'd1, busy_now);
        end else begin
            check_value({side, "_busy"}, 32'd0, busy_now);
            // result holds after done
            if (active && check_data)
                check_value(data_name, expected, data_now);
        end
    endtask

    task automatic run_case(
        input logic [7:0] op,
        input bus_addr_t  f_addr,
        input bus_addr_t  l_addr,
        input bus_data_t  st_data,
        input bus_data_t  exp_f,
        input bus_data_t  exp_l
    );
        logic       do_fetch;
        logic       do_lsu;
        logic       is_store;
        logic       f_seen;
        logic       l_seen;
        int         cyc;
        int         f_cyc;
        int         l_cyc;
        logic [7:0] f_idx;
        logic [7:0] l_idx;

        do_fetch = (op == "F") || (op == "B");
        do_lsu   = (op == "L") || (op == "S") || (op == "B");
        is_store = (op == "S");
        f_idx    = f_addr[9:2];
        l_idx    = l_addr[9:2];
        if (!do_fetch && !do_lsu) begin
            $display("unknown operation code %s in the case file", op);
            stop_with_failure();
        end

        // case line must agree with the model
        if (do_fetch) begin
            if (!ref_valid[f_idx]) begin
                $display("case fetches word %h before any store wrote it", f_addr);
                stop_with_failure();
            end
            check_value("case file fetch data", ref_mem[f_idx], exp_f);
        end
        if (do_lsu && !is_store) begin
            if (!ref_valid[l_idx]) begin
                $display("case loads word %h before any store wrote it", l_addr);
                stop_with_failure();
            end
            check_value("case file load data", ref_mem[l_idx], exp_l);
        end

        // both strobes in the same cycle for B
        @(posedge clk);
        fetch_req  <= do_fetch;
        fetch_addr <= f_addr;
        lsu_req    <= do_lsu;
        lsu_we     <= is_store;
        lsu_addr   <= l_addr;
        lsu_wdata  <= st_data;

        cyc    = 0;
        f_cyc  = 0;
        l_cyc  = 0;
        f_seen = 1'b0;
        l_seen = 1'b0;
        while ((do_fetch && !f_seen) || (do_lsu && !l_seen)) begin
            @(posedge clk);
            fetch_req <= 1'b0;
            lsu_req   <= 1'b0;
            cyc++;
            @(negedge clk);
            watch_side("fetch", "fetch_data", do_fetch, 1'b1, fetch_done, fetch_busy,
                       fetch_data, exp_f, cyc, f_seen, f_cyc);
            watch_side("lsu", "lsu_rdata", do_lsu, !is_store, lsu_done, lsu_busy,
                       lsu_rdata, exp_l, cyc, l_seen, l_cyc);
            if (cyc >= TIMEOUT_CYCLES && ((do_fetch && !f_seen) || (do_lsu && !l_seen))) begin
                $display("timeout at %0t ns: case %s did not finish within %0d cycles",
                         $time, op, TIMEOUT_CYCLES);
                stop_with_failure();
            end
        end

        // uncontended reads take a fixed time
        if (op == "F")
            check_value("fetch_done cycle", SRAM_LAT + 4, f_cyc);
        if (op == "L")
            check_value("lsu_done cycle", SRAM_LAT + 4, l_cyc);
        // fetch wins the bus when both ask together
        if (op == "B" && f_cyc >= l_cyc) begin
            $display("fetch_done did not come before lsu_done at %0t ns", $time);
            stop_with_failure();
        end
        if (is_store) begin
            ref_mem[l_idx]   = st_data;
            ref_valid[l_idx] = 1'b1;
        end
    endtask

    initial begin
        int        fd;
        int        n;
        int        cases;
        int        gap;
        string     line;
        logic [7:0] op;
        bus_addr_t fa;
        bus_addr_t la;
        bus_data_t wd;
        bus_data_t ef;
        bus_data_t el;

        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        lsu_req    = 1'b0;
        lsu_we     = 1'b0;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        rng        = SEED;
        cases      = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_valid[i] = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // outputs stay quiet until the first request
        idle_cycles(4);

        fd = $fopen("test/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mem_cases.txt");
            stop_with_failure();
        end

        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank lines and column notes
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%c %h %h %h %h %h", op, fa, la, wd, ef, el);
            if (n != 6) begin
                $display("malformed case line: %s", line);
                stop_with_failure();
            end
            // random gap of 0 to 3 cycles
            rng = next_random(rng);
            gap = rng % 4;
            idle_cycles(gap);
            run_case(op, fa, la, wd, ef, el);
            cases++;
        end
        $fclose(fd);

        if (cases == 0) begin
            $display("no cases found in test/mem_cases.txt");
            stop_with_failure();
        end
        idle_cycles(2);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: test/mem_cases.txt
# op fetch_addr lsu_addr store_data exp_fetch exp_load (hex)
# op: F fetch, L load, S store, B fetch and load together; unused columns are zero
S 00000000 00000040 deadbeef 00000000 00000000
L 00000000 00000040 00000000 00000000 deadbeef
F 00000040 00000000 00000000 deadbeef 00000000
S 00000000 00000044 13579bdf 00000000 00000000
S 00000000 00000048 2468ace0 00000000 00000000
S 00000000 000003fc a5a5a5a5 00000000 00000000
L 00000000 00000044 00000000 00000000 13579bdf
L 00000000 00000048 00000000 00000000 2468ace0
L 00000000 00000040 00000000 00000000 deadbeef
S 00000000 00000044 0badf00d 00000000 00000000
L 00000000 00000044 00000000 00000000 0badf00d
L 00000000 00000048 00000000 00000000 2468ace0
B 00000040 00000044 00000000 deadbeef 0badf00d
B 000003fc 00000048 00000000 a5a5a5a5 2468ace0
F 00000044 00000000 00000000 0badf00d 00000000
S 00000000 00000100 cafef00d 00000000 00000000
B 00000100 00000100 00000000 cafef00d cafef00d
L 00000000 000003fc 00000000 00000000 a5a5a5a5
S 00000000 00000400 11112222 00000000 00000000
F 00000000 00000000 00000000 11112222 00000000
L 00000000 00000000 00000000 00000000 11112222

// File: mem_subsystem.f
design/mem_bus_pkg.sv
design/bus_arbiter.sv
design/fetch_bus_master.sv
design/lsu_bus_master.sv
design/sram_slave.sv
design/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - design/mem_bus_pkg.sv
      - design/bus_arbiter.sv
      - design/fetch_bus_master.sv
      - design/lsu_bus_master.sv
      - design/sram_slave.sv
      - design/mem_subsystem_top.sv
  - target: test
    files:
      - test/tb_mem_subsystem.sv
